// ==== list.f ====
+incdir+include
rtl/cnn_pkg.sv
rtl/pix_stream_if.sv
rtl/window_scanner.sv
rtl/conv_stage.sv
rtl/pool_stage.sv
rtl/dense_stage.sv
rtl/cnn_top.sv
verif/cnn_assertions.sv
verif/cnn_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the cnn testbench with verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module cnn_tb -f list.f -o cnn_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/cnn_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# verdict comes from the testbench's own closing message
if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

// ==== verif/cnn_tb.sv ====
`default_nettype none

`include "cnn_defines.svh"

module cnn_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cnn_pkg::*;

    typedef enum int {MODE_RAND, MODE_MAX, MODE_MIN, MODE_ZERO_KER} data_mode_t;

    localparam int TBL_LEN     = 6;
    localparam int DONE_WAIT   = 200;                  // start to dense_done, generous
    localparam int CYCLE_LIMIT = TBL_LEN * 300 + 10;  // 300 per row plus reset

    // ********************
    // test table
    // ********************
    string      tbl_name   [TBL_LEN] = '{"random_a", "random_b", "all_max", "all_min",
                                         "zero_kernel", "rerun_no_load"};
    data_mode_t tbl_mode   [TBL_LEN] = '{MODE_RAND, MODE_RAND, MODE_MAX, MODE_MIN,
                                         MODE_ZERO_KER, MODE_ZERO_KER};
    bit         tbl_reload [TBL_LEN] = '{1, 1, 1, 1, 1, 0};  // last row reuses loaded data
    bit         tbl_fixed  [TBL_LEN] = '{0, 0, 1, 1, 0, 0};  // saturated score known
    score_t     tbl_exp    [TBL_LEN] = '{8'sd0, 8'sd0, 8'sd127, -8'sd128, 8'sd0, 8'sd0};

    logic       clk;
    logic       rst;
    logic       load_en;
    load_addr_t load_addr;
    pixel_t     load_data;
    logic       start;
    class_t     class_sel;
    score_t     score;
    logic       conv_done;
    logic       pool_done;
    logic       dense_done;

    // host side copy of everything loaded
    pixel_t      img   [`IMG_DIM * `IMG_DIM];
    weight_t     ker   [`KER_DIM * `KER_DIM];
    weight_t     cbias;
    weight_t     dw    [`NUM_CLASSES * `POOL_LEN];
    weight_t     dbias [`NUM_CLASSES];
    score_t      exp_score [`NUM_CLASSES];
    logic [31:0] lcg_state = 32'ha61c_68a0;
    int          errors = 0;
    int          cycles = 0;

    cnn_top DUT (
        .clk(clk), .rst(rst), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .start(start), .class_sel(class_sel), .score(score),
        .conv_done(conv_done), .pool_done(pool_done), .dense_done(dense_done)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit
    initial
    begin
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("sim failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic pixel_t mode_byte(data_mode_t mode, int shift);
        logic [31:0] r;
        r = lcg_next();
        if (mode == MODE_MAX)
            return 8'sd127;
        if (mode == MODE_MIN)
            return -8'sd128;
        return pixel_t'(r[23:16]) >>> shift;  // shift keeps random sums off the rails
    endfunction

    function automatic int saturate(int v);
        if (v > 127)
            return 127;
        if (v < -128)
            return -128;
        return v;
    endfunction

    function automatic int max_int(int a, int b);
        return (a > b) ? a : b;
    endfunction

    task automatic fill_data(data_mode_t mode);
        foreach (img[i])
            img[i] = mode_byte(mode, 0);
        foreach (ker[i])
            ker[i] = (mode == MODE_ZERO_KER) ? 8'sd0 : mode_byte(mode, 2);
        cbias = (mode == MODE_ZERO_KER) ? 8'sd100 : mode_byte(mode, 0);  // conv out 1 everywhere
        foreach (dw[i])
            dw[i] = mode_byte(mode, 2);
        foreach (dbias[i])
            dbias[i] = mode_byte(mode, 0);
    endtask

    task automatic load_byte(int addr, pixel_t data);
        @(negedge clk);
        load_en   = 1'b1;
        load_addr = load_addr_t'(addr);
        load_data = data;
    endtask

    task automatic load_all();
        foreach (img[i])
            load_byte(`ADDR_IMG + i, img[i]);
        foreach (ker[i])
            load_byte(`ADDR_KER + i, ker[i]);
        load_byte(`ADDR_CBIAS, cbias);
        foreach (dw[i])
            load_byte(`ADDR_DW + i, dw[i]);  // class major, 80 + 9c + k
        foreach (dbias[i])
            load_byte(`ADDR_DBIAS + i, dbias[i]);
        @(negedge clk);
        load_en = 1'b0;
    endtask

    // ********************
    // reference model
    // ********************
    task automatic compute_model();
        int conv [`CONV_DIM][`CONV_DIM];
        int pool [`POOL_LEN];
        int s;
        for (int r = 0; r < `CONV_DIM; r++)
            for (int c = 0; c < `CONV_DIM; c++)
            begin
                s = cbias;
                for (int i = 0; i < `KER_DIM; i++)
                    for (int j = 0; j < `KER_DIM; j++)
                        s += img[(r + i) * `IMG_DIM + c + j] * ker[i * `KER_DIM + j];
                conv[r][c] = saturate(s >>> `CONV_SHIFT);
            end
        for (int pr = 0; pr < `POOL_DIM; pr++)
            for (int pc = 0; pc < `POOL_DIM; pc++)
                pool[pr * `POOL_DIM + pc] =
                    max_int(max_int(conv[2 * pr][2 * pc], conv[2 * pr][2 * pc + 1]),
                            max_int(conv[2 * pr + 1][2 * pc], conv[2 * pr + 1][2 * pc + 1]));
        for (int cl = 0; cl < `NUM_CLASSES; cl++)
        begin
            s = dbias[cl];
            for (int k = 0; k < `POOL_LEN; k++)
                s += pool[k] * dw[cl * `POOL_LEN + k];
            exp_score[cl] = score_t'(saturate(s >>> `DENSE_SHIFT));
        end
    endtask

    task automatic check_score(string name, score_t exp, score_t act);
        if (act !== exp)
        begin
            errors++;
            $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(string name, bit exp, bit act);
        if (act !== exp)
        begin
            errors++;
            $display("Mismatch %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    task automatic run_row(int t);
        int    n;
        int    conv_at;
        int    pool_at;
        int    dense_at;
        string name;
        name = tbl_name[t];
        if (tbl_reload[t])
        begin
            fill_data(tbl_mode[t]);
            load_all();
        end
        compute_model();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_flag({name, " conv_done cleared"}, 1'b0, conv_done);  // accepted start clears all
        check_flag({name, " pool_done cleared"}, 1'b0, pool_done);
        check_flag({name, " dense_done cleared"}, 1'b0, dense_done);
        n        = 0;
        conv_at  = -1;
        pool_at  = -1;
        dense_at = -1;
        while (!dense_done && n < DONE_WAIT)
        begin
            @(negedge clk);
            n++;
            start = (n == 20);  // mid frame, pool stream already running
            if (conv_done && conv_at < 0)
                conv_at = n;
            if (pool_done && pool_at < 0)
                pool_at = n;
            if (dense_done && dense_at < 0)
                dense_at = n;
        end
        start = 1'b0;
        if (!dense_done)
        begin
            errors++;
            $display("%s: dense_done did not rise within %0d cycles", name, DONE_WAIT);
        end
        else if (!(conv_at > 0 && conv_at < pool_at && pool_at <= dense_at))
        begin
            errors++;
            $display("%s: flags rose out of order, conv %0d pool %0d dense %0d",
                     name, conv_at, pool_at, dense_at);
        end
        for (int c = 0; c < `NUM_CLASSES; c++)
        begin
            @(negedge clk);
            class_sel = class_t'(c);
            @(negedge clk);                           // score is a mux, settled by now
            check_score($sformatf("%s class %0d", name, c), exp_score[c], score);
            if (tbl_fixed[t])
                check_score($sformatf("%s class %0d saturated", name, c), tbl_exp[t], score);
        end
        check_flag({name, " conv_done held"}, 1'b1, conv_done);
        check_flag({name, " pool_done held"}, 1'b1, pool_done);
        check_flag({name, " dense_done held"}, 1'b1, dense_done);
    endtask

    initial
    begin
        rst       = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        start     = 1'b0;
        class_sel = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_flag("reset conv_done", 1'b0, conv_done);
        check_flag("reset pool_done", 1'b0, pool_done);
        check_flag("reset dense_done", 1'b0, dense_done);
        for (int t = 0; t < TBL_LEN; t++)
            run_row(t);
        repeat (2) @(negedge clk);
        $display("errors: %0d testbench, %0d assertion", errors, DUT.u_assertions.fail_count);
        if (errors == 0 && DUT.u_assertions.fail_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/cnn_assertions.sv ====
`default_nettype none

module cnn_assertions (
    input logic clk,
    input logic rst,
    input logic conv_valid,  // conv_if strobe inside cnn_top
    input logic busy,        // scanner frame in flight
    input logic conv_done,
    input logic pool_done,
    input logic dense_done
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // read back by the testbench

    // ********************
    // flag ordering
    // ********************
    pool_after_conv: assert property (@(posedge clk) disable iff (rst) pool_done |-> conv_done)
        else
        begin
            $error("pool_done high while conv_done is low");
            fail_count++;
        end

    dense_after_pool: assert property (@(posedge clk) disable iff (rst) dense_done |-> pool_done)
        else
        begin
            $error("dense_done high while pool_done is low");
            fail_count++;
        end

    // conv stream only inside a frame
    conv_in_frame: assert property (@(posedge clk) disable iff (rst) conv_valid |-> busy)
        else
        begin
            $error("conv stream valid while the scanner is idle");
            fail_count++;
        end

    flags_after_reset: assert property (@(posedge clk)
            rst |=> (!conv_done && !pool_done && !dense_done))
        else
        begin
            $error("done flags not cleared by reset");
            fail_count++;
        end

endmodule

bind cnn_top cnn_assertions u_assertions (
    .clk(clk), .rst(rst), .conv_valid(conv_if.valid), .busy(busy),
    .conv_done(conv_done), .pool_done(pool_done), .dense_done(dense_done)
);

`default_nettype wire

// ==== rtl/cnn_top.sv ====
`default_nettype none

module cnn_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                load_en,
    input  cnn_pkg::load_addr_t load_addr,
    input  cnn_pkg::pixel_t     load_data,
    input  logic                start,
    input  cnn_pkg::class_t     class_sel,
    output cnn_pkg::score_t     score,
    output logic                conv_done,
    output logic                pool_done,
    output logic                dense_done
);
    import cnn_pkg::*;

    window_t win;
    logic    win_valid;
    logic    win_last;
    logic    busy;
    logic    frame_start;  // start accepted only while idle

    pix_stream_if conv_if ();  // conv -> pool
    pix_stream_if pool_if ();  // pool -> dense

    assign frame_start = start && !busy;

    // ********************
    // stages
    // ********************
    window_scanner u_scan (
        .clk(clk), .rst(rst), .start(frame_start), .frame_done(dense_done),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .win_valid(win_valid), .win(win), .win_last(win_last), .busy(busy)
    );

    conv_stage u_conv (
        .clk(clk), .rst(rst), .start(frame_start),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .win_valid(win_valid), .win(win), .win_last(win_last),
        .conv_done(conv_done), .out(conv_if)
    );

    pool_stage u_pool (
        .clk(clk), .rst(rst), .start(frame_start), .pool_done(pool_done),
        .in(conv_if), .out(pool_if)
    );

    dense_stage u_dense (
        .clk(clk), .rst(rst), .start(frame_start),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .class_sel(class_sel), .score(score), .dense_done(dense_done), .in(pool_if)
    );

endmodule

`default_nettype wire

// ==== rtl/dense_stage.sv ====
`default_nettype none

`include "cnn_defines.svh"

module dense_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                load_en,
    input  cnn_pkg::load_addr_t load_addr,
    input  cnn_pkg::weight_t    load_data,
    input  cnn_pkg::class_t     class_sel,
    output cnn_pkg::score_t     score,
    output logic                dense_done,
    pix_stream_if.dst           in
);
    import cnn_pkg::*;

    weight_t    dw [`NUM_CLASSES * `POOL_LEN];  // class major
    weight_t    dbias [`NUM_CLASSES];
    acc_t       acc [`NUM_CLASSES];
    acc_t       acc_next [`NUM_CLASSES];
    score_t     score_q [`NUM_CLASSES];
    logic [3:0] pos;                            // flat index of pooled value

    // ********************
    // weight memory
    // ********************
    always_ff @(posedge clk)
    begin
        if (load_en && load_addr >= 7'(`ADDR_DW) && load_addr < 7'(`ADDR_DW_END))
            dw[6'(load_addr - 7'(`ADDR_DW))] <= load_data;
        if (load_en && load_addr >= 7'(`ADDR_DBIAS) && load_addr < 7'(`ADDR_DBIAS_END))
            dbias[2'(load_addr - 7'(`ADDR_DBIAS))] <= load_data;
    end

    assign pos = 4'(in.row * `POOL_DIM + in.col);

    // one pooled value feeds all classes at once
    always_comb
    begin
        for (int c = 0; c < `NUM_CLASSES; c++)
            acc_next[c] = acc[c] + in.data * dw[6'(c * `POOL_LEN + int'(pos))];
    end

    // ********************
    // accumulate
    // ********************
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            for (int c = 0; c < `NUM_CLASSES; c++)
                acc[c] <= '0;
        end
        else if (in.valid)
            acc <= acc_next;
    end

    // requant straight from acc_next so scores land with done
    always_ff @(posedge clk)
    begin
        if (in.valid && in.last)
        begin
            for (int c = 0; c < `NUM_CLASSES; c++)
                score_q[c] <= requant(acc_next[c], dbias[c], `DENSE_SHIFT);
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            dense_done <= 1'b0;
        else if (start)
            dense_done <= 1'b0;
        else if (in.valid && in.last)
            dense_done <= 1'b1;  // held until next frame
    end

    assign score = score_q[class_sel];  // host read mux

endmodule

`default_nettype wire

// ==== rtl/pool_stage.sv ====
`default_nettype none

`include "cnn_defines.svh"

module pool_stage (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    output logic      pool_done,
    pix_stream_if.dst in,
    pix_stream_if.src out
);
    import cnn_pkg::*;

    pixel_t pair_lo;                 // even column value of current pair
    pixel_t rowbuf [`POOL_DIM];      // pair maxima of the even row
    pixel_t pair_max;
    logic   odd_pos;                 // odd row and odd column

    function automatic pixel_t max2(pixel_t a, pixel_t b);
        return (a > b) ? a : b;      // signed compare
    endfunction

    assign pair_max = max2(pair_lo, in.data);
    assign odd_pos  = in.row[0] && in.col[0];

    // ********************
    // pair and row buffer
    // ********************
    always_ff @(posedge clk)
    begin
        if (in.valid)
        begin
            if (!in.col[0])
                pair_lo <= in.data;
            else if (!in.row[0])
                rowbuf[in.col[2:1]] <= pair_max;  // col >> 1
        end
    end

    always_ff @(posedge clk)
    begin
        if (in.valid && odd_pos)
        begin
            out.data <= max2(rowbuf[in.col[2:1]], pair_max);
            out.row  <= in.row >> 1;
            out.col  <= in.col >> 1;
        end
    end

    // ********************
    // control
    // ********************
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out.valid <= 1'b0;
            out.last  <= 1'b0;
            pool_done <= 1'b0;
        end
        else
        begin
            out.valid <= in.valid && odd_pos;
            out.last  <= in.valid && odd_pos && in.last; // conv (5,5) gives ninth output
            if (start)
                pool_done <= 1'b0;
            else if (out.valid && out.last)
                pool_done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/conv_stage.sv ====
`default_nettype none

`include "cnn_defines.svh"

module conv_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                load_en,
    input  cnn_pkg::load_addr_t load_addr,
    input  cnn_pkg::weight_t    load_data,
    input  logic                win_valid,
    input  cnn_pkg::window_t    win,
    input  logic                win_last,
    output logic                conv_done,
    pix_stream_if.src           out
);
    import cnn_pkg::*;

    weight_t           ker [`KER_DIM * `KER_DIM];
    weight_t           cbias;
    logic signed [15:0] prod [`KER_DIM * `KER_DIM];  // step 1 products
    logic              prod_valid;
    logic              prod_last;
    acc_t              sum;
    logic [2:0]        cnt_row;   // position of next output
    logic [2:0]        cnt_col;

    // kernel and bias from the load port
    always_ff @(posedge clk)
    begin
        if (load_en && load_addr >= 7'(`ADDR_KER) && load_addr < 7'(`ADDR_KER_END))
            ker[4'(load_addr - 7'(`ADDR_KER))] <= load_data;
        if (load_en && load_addr == 7'(`ADDR_CBIAS))
            cbias <= load_data;
    end

    // ********************
    // step 1, multiply
    // ********************
    always_ff @(posedge clk)
    begin
        if (win_valid)
        begin
            for (int k = 0; k < `KER_DIM * `KER_DIM; k++)
                prod[k] <= win[k] * ker[k];
        end
    end

    always_comb
    begin
        sum = '0;
        for (int k = 0; k < `KER_DIM * `KER_DIM; k++)
            sum = sum + prod[k];  // sign extended into acc width
    end

    // ********************
    // step 2, sum and requant
    // ********************
    always_ff @(posedge clk)
    begin
        if (prod_valid)
        begin
            out.data <= requant(sum, cbias, `CONV_SHIFT);
            out.row  <= cnt_row;
            out.col  <= cnt_col;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            prod_valid <= 1'b0;
            prod_last  <= 1'b0;
            out.valid  <= 1'b0;
            out.last   <= 1'b0;
            cnt_row    <= '0;
            cnt_col    <= '0;
            conv_done  <= 1'b0;
        end
        else
        begin
            prod_valid <= win_valid;
            prod_last  <= win_valid && win_last;
            out.valid  <= prod_valid;
            out.last   <= prod_valid && prod_last;
            if (start)
            begin
                cnt_row <= '0;
                cnt_col <= '0;
            end
            else if (prod_valid)
            begin
                if (cnt_col == 3'(`CONV_DIM - 1))
                begin
                    cnt_col <= '0;
                    cnt_row <= cnt_row + 3'd1;
                end
                else
                    cnt_col <= cnt_col + 3'd1;
            end
            if (start)
                conv_done <= 1'b0;
            else if (out.valid && out.last)
                conv_done <= 1'b1;  // level until next frame
        end
    end

endmodule

`default_nettype wire

// ==== rtl/window_scanner.sv ====
`default_nettype none

`include "cnn_defines.svh"

module window_scanner (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,       // already qualified by top
    input  logic                frame_done,  // dense result ready
    input  logic                load_en,
    input  cnn_pkg::load_addr_t load_addr,
    input  cnn_pkg::pixel_t     load_data,
    output logic                win_valid,
    output cnn_pkg::window_t    win,
    output logic                win_last,
    output logic                busy
);
    import cnn_pkg::*;

    pixel_t      img_mem [`IMG_DIM * `IMG_DIM];
    scan_state_t state;
    logic [2:0]  row_q;      // origin of next window
    logic [2:0]  col_q;
    logic        emit;
    logic        last_origin;

    // ********************
    // image memory
    // ********************
    always_ff @(posedge clk)
    begin
        if (load_en && state == IDLE && load_addr < 7'(`ADDR_KER))
            img_mem[6'(load_addr)] <= load_data;
    end

    assign last_origin = (row_q == 3'(`CONV_DIM - 1)) && (col_q == 3'(`CONV_DIM - 1));
    assign emit        = (state == IDLE && start) || state == SCAN; // first window on start edge
    assign busy        = (state != IDLE);

    // ********************
    // scan fsm
    // ********************
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= IDLE;
            row_q     <= '0;
            col_q     <= '0;
            win_valid <= 1'b0;
            win_last  <= 1'b0;
        end
        else
        begin
            win_valid <= emit;
            win_last  <= emit && last_origin;
            if (emit)
            begin
                if (col_q == 3'(`CONV_DIM - 1))
                begin
                    col_q <= '0;
                    row_q <= last_origin ? 3'd0 : row_q + 3'd1; // wraps for next frame
                end
                else
                    col_q <= col_q + 3'd1;
            end
            case (state)
                IDLE:    if (start) state <= SCAN;
                SCAN:    if (last_origin) state <= FLUSH;
                FLUSH:   if (frame_done) state <= IDLE;  // wait out the pipeline
                default: state <= IDLE;
            endcase
        end
    end

    // gather the 3x3 neighbourhood of the current origin
    always_ff @(posedge clk)
    begin
        if (emit)
        begin
            for (int i = 0; i < `KER_DIM; i++)
                for (int j = 0; j < `KER_DIM; j++)
                    win[i * `KER_DIM + j] <= img_mem[6'((row_q + i) * `IMG_DIM + col_q + j)];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pix_stream_if.sv ====
`default_nettype none

// one int8 feature per valid strobe, no back-pressure
interface pix_stream_if;
    import cnn_pkg::*;

    logic       valid;  // one-cycle strobe
    pixel_t     data;
    logic [2:0] row;    // position of data in its feature map
    logic [2:0] col;
    logic       last;   // final item of the frame

    modport src (
        output valid, data, row, col, last
    );

    modport dst (
        input valid, data, row, col, last
    );

endinterface

`default_nettype wire

// ==== rtl/cnn_pkg.sv ====
`default_nettype none

`include "cnn_defines.svh"

package cnn_pkg;

    typedef logic signed [7:0]  pixel_t;     // image value or any int8 feature
    typedef logic signed [7:0]  weight_t;    // kernel tap, dense weight, bias
    typedef logic signed [23:0] acc_t;       // wide enough for 9-tap sums
    typedef logic signed [7:0]  score_t;     // requantized class score
    typedef logic [`LOAD_AW-1:0] load_addr_t;
    typedef logic [1:0]         class_t;

    typedef pixel_t window_t [`KER_DIM * `KER_DIM]; // 3x3 neighbourhood, row major

    typedef enum logic [1:0] {IDLE, SCAN, FLUSH} scan_state_t;

    // bias add, arithmetic shift, clamp to int8
    function automatic pixel_t requant(acc_t acc, weight_t bias, int shift);
        acc_t q;
        q = (acc + bias) >>> shift;
        if (q > acc_t'(127))
            return 8'sd127;
        else if (q < acc_t'(-128))
            return -8'sd128;
        return pixel_t'(q);
    endfunction

endpackage

`default_nettype wire

// ==== include/cnn_defines.svh ====
`ifndef CNN_DEFINES_SVH
`define CNN_DEFINES_SVH

// ********************
// geometry
// ********************
`define IMG_DIM      8   // input image side
`define KER_DIM      3   // conv kernel side
`define CONV_DIM     6   // IMG_DIM - KER_DIM + 1
`define POOL_DIM     3   // conv side after 2x2 pooling
`define POOL_LEN     9   // pooled values per frame
`define NUM_CLASSES  4   // dense layer outputs

// ********************
// requantization
// ********************
`define CONV_SHIFT   6   // arithmetic shift after conv sum
`define DENSE_SHIFT  5   // arithmetic shift after dense sum

// ********************
// load port address map
// ********************
`define LOAD_AW      7   // byte address width of the load port
`define ADDR_IMG     0   // 64 image bytes, row major
`define ADDR_KER     64  // 9 kernel taps, row major
`define ADDR_CBIAS   73  // single conv bias
`define ADDR_DW      80  // class c input k at 80 + 9c + k
`define ADDR_DBIAS   116 // class c at 116 + c

// region ends, first address past each block
`define ADDR_KER_END    (`ADDR_KER + `KER_DIM * `KER_DIM)
`define ADDR_DW_END     (`ADDR_DW + `NUM_CLASSES * `POOL_LEN)
`define ADDR_DBIAS_END  (`ADDR_DBIAS + `NUM_CLASSES)

`endif
